// File: src/mips_pkg.sv
// MIPS core shared definitions
`default_nettype none

package mips_pkg;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // function codes of R-type
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    // one instruction word, three formats
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target26;
        } j;
    } instr_t;

    localparam int unsigned IMEM_WORDS = 64;
    localparam int unsigned DMEM_WORDS = 64;
    localparam logic [31:0] RESET_PC   = 32'h0000_0000;

    // operand forward selects
    localparam logic [1:0] FWD_NONE = 2'd0;
    localparam logic [1:0] FWD_MEM  = 2'd1;
    localparam logic [1:0] FWD_WB   = 2'd2;

endpackage

`default_nettype wire

// File: src/decode.sv
// Instruction decoder
`default_nettype none

module decode (
    input  wire mips_pkg::instr_t  instr_i,
    output logic [4:0]             rs_o,
    output logic [4:0]             rt_o,
    output logic [4:0]             rd_o,
    output logic [31:0]            imm_o,
    output mips_pkg::alu_op_t      alu_op_o,
    output logic                   alu_imm_o,
    output logic                   reg_wr_o,
    output logic                   mem_read_o,
    output logic                   mem_wr_o,
    output logic                   branch_o,
    output logic                   jump_o,
    output logic [25:0]            jump_target_o
);
    import mips_pkg::*;

    always_comb begin
        rs_o          = instr_i.i.rs;
        rt_o          = instr_i.i.rt;
        rd_o          = instr_i.i.rt;
        imm_o         = {{16{instr_i.i.imm16[15]}}, instr_i.i.imm16};
        jump_target_o = instr_i.j.target26;
        alu_op_o      = ALU_ADD;
        alu_imm_o     = 1'b0;
        reg_wr_o      = 1'b0;
        mem_read_o    = 1'b0;
        mem_wr_o      = 1'b0;
        branch_o      = 1'b0;
        jump_o        = 1'b0;
        case (instr_i.r.op)
            OP_RTYPE: begin
                rd_o     = instr_i.r.rd;
                reg_wr_o = 1'b1;
                case (instr_i.r.funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    // unknown function acts as a nop
                    default: reg_wr_o = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_imm_o = 1'b1;
                reg_wr_o  = 1'b1;
            end
            OP_LW: begin
                alu_imm_o  = 1'b1;
                reg_wr_o   = 1'b1;
                mem_read_o = 1'b1;
            end
            OP_SW: begin
                alu_imm_o = 1'b1;
                mem_wr_o  = 1'b1;
            end
            OP_BEQ: begin
                alu_op_o = ALU_SUB;
                branch_o = 1'b1;
            end
            OP_J: begin
                // no sources, so a jump never waits on a load
                rs_o   = 5'd0;
                rt_o   = 5'd0;
                jump_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: src/regfile.sv
// Register file
`default_nettype none

module regfile (
    input  wire         clk,
    input  wire         reset_i,
    input  wire         we_i,
    input  wire  [4:0]  waddr_i,
    input  wire  [31:0] wdata_i,
    input  wire  [4:0]  raddr_a_i,
    input  wire  [4:0]  raddr_b_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 is hardwired, a same-cycle write is passed through
    assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 :
                       (we_i && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 :
                       (we_i && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

endmodule

`default_nettype wire

// File: src/alu.sv
// Integer ALU
`default_nettype none

module alu (
    input  wire  [31:0]             a_i,
    input  wire  [31:0]             b_i,
    input  wire  mips_pkg::alu_op_t op_i,
    output logic [31:0]             result_o,
    output logic                    zero_o
);
    import mips_pkg::*;

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            // signed compare
            ALU_SLT: result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            default: result_o = '0;
        endcase
    end

    // beq takes the branch when rs - rt is zero
    assign zero_o = (result_o == 32'd0);

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
// Pipeline hazard control
`default_nettype none

module hazard_unit (
    input  wire  [4:0] ex_rs_i,
    input  wire  [4:0] ex_rt_i,
    input  wire        ex_mem_read_i,
    input  wire  [4:0] ex_rd_i,
    input  wire  [4:0] iss_rs_i,
    input  wire  [4:0] iss_rt_i,
    input  wire  [4:0] mem_rd_i,
    input  wire        mem_reg_wr_i,
    input  wire  [4:0] wb_rd_i,
    input  wire        wb_reg_wr_i,
    input  wire        branch_taken_i,
    input  wire        jump_i,
    output logic       stall_o,
    output logic       flush_iss_o,
    output logic       flush_ex_o,
    output logic [1:0] fwd_a_o,
    output logic [1:0] fwd_b_o
);
    import mips_pkg::*;

    logic load_use;

    // memory stage is younger, so it wins over writeback
    function automatic logic [1:0] fwd_sel(input logic [4:0] src);
        if (mem_reg_wr_i && mem_rd_i != 5'd0 && mem_rd_i == src) begin
            return FWD_MEM;
        end else if (wb_reg_wr_i && wb_rd_i != 5'd0 && wb_rd_i == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign load_use = ex_mem_read_i && (ex_rd_i != 5'd0) &&
                      (ex_rd_i == iss_rs_i || ex_rd_i == iss_rt_i);

    // a load and a taken branch never share the execute stage
    assign stall_o     = load_use;
    assign flush_iss_o = branch_taken_i | jump_i;
    assign flush_ex_o  = branch_taken_i;

    assign fwd_a_o = fwd_sel(ex_rs_i);
    assign fwd_b_o = fwd_sel(ex_rt_i);

endmodule

`default_nettype wire

// File: src/mips_core.sv
// Five-stage pipelined core
`default_nettype none

module mips_core (
    input  wire                    clk,
    input  wire                    reset_i,
    output logic [31:0]            imem_addr_o,
    input  wire mips_pkg::instr_t  imem_data_i,
    output logic [31:0]            dmem_addr_o,
    output logic [31:0]            dmem_wdata_o,
    output logic                   dmem_we_o,
    input  wire  [31:0]            dmem_rdata_i,
    output logic                   wb_en_o,
    output logic [4:0]             wb_reg_o,
    output logic [31:0]            wb_data_o
);
    import mips_pkg::*;

    logic [31:0] pc, pc_plus4, pc_next, jump_pc, branch_pc;
    logic        stall, flush_iss, flush_ex, iss_jump, branch_taken;
    logic [1:0]  fwd_a, fwd_b;

    // fetch/issue
    logic        iss_valid;
    logic [31:0] iss_pc4;
    instr_t      iss_instr;
    logic [4:0]  dec_rs, dec_rt, dec_rd;
    logic [31:0] dec_imm, rf_a, rf_b;
    alu_op_t     dec_alu_op;
    logic        dec_alu_imm, dec_reg_wr, dec_mem_read, dec_mem_wr, dec_branch, dec_jump;
    logic [25:0] dec_target;

    // issue/execute
    logic        ex_valid, ex_reg_wr, ex_mem_read, ex_mem_wr, ex_branch, ex_alu_imm;
    alu_op_t     ex_alu_op;
    logic [4:0]  ex_rs, ex_rt, ex_rd;
    logic [31:0] ex_a, ex_b, ex_imm, ex_pc4;
    logic [31:0] opnd_a, opnd_b, alu_b, alu_res;
    logic        alu_zero;

    // execute/memory and memory/writeback
    logic        mem_valid, mem_reg_wr, mem_mem_read, mem_mem_wr;
    logic [4:0]  mem_rd;
    logic [31:0] mem_alu, mem_store;
    logic        wb_valid, wb_reg_wr;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // fetch
    assign pc_plus4    = pc + 32'd4;
    assign jump_pc     = {iss_pc4[31:28], dec_target, 2'b00};
    assign pc_next     = branch_taken ? branch_pc : iss_jump ? jump_pc : pc_plus4;
    assign imem_addr_o = pc;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_iss) begin
            iss_valid <= 1'b0;
        end else if (!stall) begin
            iss_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            iss_pc4   <= pc_plus4;
            iss_instr <= imem_data_i;
        end
    end

    // issue
    decode u_decode (
        .instr_i       (iss_instr),
        .rs_o          (dec_rs),
        .rt_o          (dec_rt),
        .rd_o          (dec_rd),
        .imm_o         (dec_imm),
        .alu_op_o      (dec_alu_op),
        .alu_imm_o     (dec_alu_imm),
        .reg_wr_o      (dec_reg_wr),
        .mem_read_o    (dec_mem_read),
        .mem_wr_o      (dec_mem_wr),
        .branch_o      (dec_branch),
        .jump_o        (dec_jump),
        .jump_target_o (dec_target)
    );

    regfile u_regfile (
        .clk       (clk),
        .reset_i   (reset_i),
        .we_i      (wb_en_o),
        .waddr_i   (wb_rd),
        .wdata_i   (wb_data),
        .raddr_a_i (dec_rs),
        .raddr_b_i (dec_rt),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b)
    );

    assign iss_jump = iss_valid & dec_jump;

    // a stall leaves a bubble behind in execute
    always_ff @(posedge clk) begin
        if (reset_i || flush_ex || stall) begin
            ex_valid    <= 1'b0;
            ex_reg_wr   <= 1'b0;
            ex_mem_read <= 1'b0;
            ex_mem_wr   <= 1'b0;
            ex_branch   <= 1'b0;
        end else begin
            ex_valid    <= iss_valid;
            ex_reg_wr   <= dec_reg_wr;
            ex_mem_read <= dec_mem_read;
            ex_mem_wr   <= dec_mem_wr;
            ex_branch   <= dec_branch;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op  <= dec_alu_op;
        ex_alu_imm <= dec_alu_imm;
        ex_rs      <= dec_rs;
        ex_rt      <= dec_rt;
        ex_rd      <= dec_rd;
        ex_a       <= rf_a;
        ex_b       <= rf_b;
        ex_imm     <= dec_imm;
        ex_pc4     <= iss_pc4;
    end

    // execute
    assign opnd_a = (fwd_a == FWD_MEM) ? mem_alu : (fwd_a == FWD_WB) ? wb_data : ex_a;
    assign opnd_b = (fwd_b == FWD_MEM) ? mem_alu : (fwd_b == FWD_WB) ? wb_data : ex_b;
    assign alu_b  = ex_alu_imm ? ex_imm : opnd_b;

    alu u_alu (
        .a_i      (opnd_a),
        .b_i      (alu_b),
        .op_i     (ex_alu_op),
        .result_o (alu_res),
        .zero_o   (alu_zero)
    );

    assign branch_pc    = ex_pc4 + {ex_imm[29:0], 2'b00};
    assign branch_taken = ex_valid & ex_branch & alu_zero;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_valid    <= 1'b0;
            mem_reg_wr   <= 1'b0;
            mem_mem_read <= 1'b0;
            mem_mem_wr   <= 1'b0;
        end else begin
            mem_valid    <= ex_valid;
            mem_reg_wr   <= ex_reg_wr;
            mem_mem_read <= ex_mem_read;
            mem_mem_wr   <= ex_mem_wr;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd    <= ex_rd;
        mem_alu   <= alu_res;
        mem_store <= opnd_b;
    end

    // memory
    assign dmem_addr_o  = mem_alu;
    assign dmem_wdata_o = mem_store;
    assign dmem_we_o    = mem_valid & mem_mem_wr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid  <= 1'b0;
            wb_reg_wr <= 1'b0;
        end else begin
            wb_valid  <= mem_valid;
            wb_reg_wr <= mem_reg_wr;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_mem_read ? dmem_rdata_i : mem_alu;
    end

    // writeback, r0 never written
    assign wb_en_o   = wb_valid & wb_reg_wr & (wb_rd != 5'd0);
    assign wb_reg_o  = wb_rd;
    assign wb_data_o = wb_data;

    hazard_unit u_hazard_unit (
        .ex_rs_i        (ex_rs),
        .ex_rt_i        (ex_rt),
        .ex_mem_read_i  (ex_valid & ex_mem_read),
        .ex_rd_i        (ex_rd),
        .iss_rs_i       (dec_rs),
        .iss_rt_i       (dec_rt),
        .mem_rd_i       (mem_rd),
        .mem_reg_wr_i   (mem_valid & mem_reg_wr),
        .wb_rd_i        (wb_rd),
        .wb_reg_wr_i    (wb_en_o),
        .branch_taken_i (branch_taken),
        .jump_i         (iss_jump),
        .stall_o        (stall),
        .flush_iss_o    (flush_iss),
        .flush_ex_o     (flush_ex),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b)
    );

endmodule

`default_nettype wire

// File: src/instr_rom.sv
// Instruction ROM
`default_nettype none

module instr_rom (
    input  wire  [31:0]            addr_i,
    output mips_pkg::instr_t       instr_o
);
    import mips_pkg::*;

    logic [31:0] rom [IMEM_WORDS];
    logic [29:0] word_idx;

    initial begin
        for (int i = 0; i < int'(IMEM_WORDS); i++) begin
            rom[i] = '0;
        end
        $readmemh("program.hex", rom);
    end

    // past the end of the image reads as a nop
    assign word_idx = addr_i[31:2];
    assign instr_o  = (word_idx < IMEM_WORDS) ? rom[word_idx[$clog2(IMEM_WORDS)-1:0]] : '0;

endmodule

`default_nettype wire

// File: src/data_ram.sv
// Data RAM
`default_nettype none

module data_ram (
    input  wire         clk,
    input  wire         we_i,
    input  wire  [31:0] addr_i,
    input  wire  [31:0] wdata_i,
    output logic [31:0] rdata_o
);
    import mips_pkg::*;

    logic [31:0]                     ram [DMEM_WORDS];
    logic [$clog2(DMEM_WORDS)-1:0]   idx;

    // word address wraps at the RAM depth
    assign idx = addr_i[$clog2(DMEM_WORDS)+1:2];

    always_ff @(posedge clk) begin
        if (we_i) begin
            ram[idx] <= wdata_i;
        end
    end

    assign rdata_o = ram[idx];

endmodule

`default_nettype wire

// File: src/mips_top.sv
// Core with instruction and data memories
`default_nettype none

module mips_top (
    input  wire         clk,
    input  wire         reset_i,
    output logic        wb_en_o,
    output logic [4:0]  wb_reg_o,
    output logic [31:0] wb_data_o,
    output logic        st_en_o,
    output logic [31:0] st_addr_o,
    output logic [31:0] st_data_o
);
    import mips_pkg::*;

    logic [31:0] imem_addr;
    instr_t      imem_data;
    logic [31:0] dmem_rdata;

    // the store ports share the data RAM write lines
    mips_core u_mips_core (
        .clk          (clk),
        .reset_i      (reset_i),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_addr_o  (st_addr_o),
        .dmem_wdata_o (st_data_o),
        .dmem_we_o    (st_en_o),
        .dmem_rdata_i (dmem_rdata),
        .wb_en_o      (wb_en_o),
        .wb_reg_o     (wb_reg_o),
        .wb_data_o    (wb_data_o)
    );

    instr_rom u_instr_rom (
        .addr_i  (imem_addr),
        .instr_o (imem_data)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .we_i    (st_en_o),
        .addr_i  (st_addr_o),
        .wdata_i (st_data_o),
        .rdata_o (dmem_rdata)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
// Testbench clock and reset
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // reset drops on a falling edge, away from the DUT's clock edge
    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: test/tb_mips_top.sv
// MIPS pipeline testbench
`default_nettype none

module tb_mips_top;
    timeunit 1ns;
    timeprecision 100ps;
    import mips_pkg::*;

    localparam int NUM_TESTS = 5;
    localparam int MAX_STEPS = 4 * IMEM_WORDS;

    logic        clk;
    logic        reset;
    logic        wb_en;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic        st_en;
    logic [31:0] st_addr;
    logic [31:0] st_data;

    // reference model state
    logic [31:0] prog [IMEM_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [DMEM_WORDS];
    int          model_steps = 0;
    logic        model_done = 1'b0;

    // expected events in program order, kind 1 is a store
    logic        exp_kind [$];
    logic [31:0] exp_where [$];
    logic [31:0] exp_data [$];
    int          exp_test [$];

    int error_count = 0;
    int check_count = 0;
    int cur_test = 0;
    int test_events [NUM_TESTS];
    int test_errors [NUM_TESTS];

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (16)
    ) u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    mips_top u_mips_top (
        .clk       (clk),
        .reset_i   (reset),
        .wb_en_o   (wb_en),
        .wb_reg_o  (wb_reg),
        .wb_data_o (wb_data),
        .st_en_o   (st_en),
        .st_addr_o (st_addr),
        .st_data_o (st_data)
    );

    // sections of program.hex start at words 8, 12, 16 and 21
    function automatic int test_of(input logic [31:0] pc);
        int w;
        w = int'(pc >> 2);
        if (w < 8) return 0;
        if (w < 12) return 1;
        if (w < 16) return 2;
        if (w < 21) return 3;
        return 4;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0:       return "alu operations";
            1:       return "forwarding";
            2:       return "load use and store load";
            3:       return "beq taken and not taken";
            default: return "jump and register zero";
        endcase
    endfunction

    function automatic void expect_event(input logic kind, input logic [31:0] where,
                                         input logic [31:0] data, input int t);
        exp_kind.push_back(kind);
        exp_where.push_back(where);
        exp_data.push_back(data);
        exp_test.push_back(t);
    endfunction

    // executes one instruction in order and returns the next pc
    function automatic logic [31:0] model_step(input logic [31:0] pc);
        logic [31:0] ins;
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] pc4;
        logic [31:0] next_pc;
        logic [31:0] res;
        logic [31:0] addr;
        logic        wr;
        int          w;
        int          t;
        w       = int'(pc >> 2);
        ins     = (w < int'(IMEM_WORDS)) ? prog[w] : 32'd0;
        op      = ins[31:26];
        rs      = ins[25:21];
        rt      = ins[20:16];
        rd      = ins[15:11];
        a       = model_regs[rs];
        b       = model_regs[rt];
        imm     = {{16{ins[15]}}, ins[15:0]};
        pc4     = pc + 32'd4;
        next_pc = pc4;
        res     = 32'd0;
        wr      = 1'b0;
        t       = test_of(pc);
        case (op)
            OP_RTYPE: begin
                wr = 1'b1;
                case (ins[5:0])
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                rd  = rt;
                res = a + imm;
                wr  = 1'b1;
            end
            OP_LW: begin
                rd   = rt;
                addr = a + imm;
                res  = model_mem[int'((addr >> 2) % DMEM_WORDS)];
                wr   = 1'b1;
            end
            OP_SW: begin
                addr = a + imm;
                model_mem[int'((addr >> 2) % DMEM_WORDS)] = b;
                expect_event(1'b1, addr, b, t);
            end
            OP_BEQ: begin
                if (a == b) begin
                    next_pc = pc4 + {imm[29:0], 2'b00};
                end
            end
            OP_J: next_pc = {pc4[31:28], ins[25:0], 2'b00};
            default: ;
        endcase
        if (wr && rd != 5'd0) begin
            model_regs[rd] = res;
            expect_event(1'b0, {27'd0, rd}, res, t);
        end
        return next_pc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
            test_errors[cur_test]++;
        end
    endtask

    task automatic report_test(input int t);
        $display("test %0d %s: %0d events, %0d errors, %s", t + 1, test_name(t),
                 test_events[t], test_errors[t], (test_errors[t] == 0) ? "ok" : "failed");
    endtask

    task automatic take_event(input logic kind, input logic [31:0] where,
                              input logic [31:0] data);
        logic        e_kind;
        logic [31:0] e_where;
        logic [31:0] e_data;
        int          t;
        if (exp_kind.size() == 0) begin
            $display("%0d ns: the DUT made a %s after all expected events", $time,
                     kind ? "store" : "register write");
            error_count++;
            return;
        end
        e_kind   = exp_kind.pop_front();
        e_where  = exp_where.pop_front();
        e_data   = exp_data.pop_front();
        t        = exp_test.pop_front();
        cur_test = t;
        test_events[t]++;
        if (e_kind != kind) begin
            $display("%0d ns: expected a %s but the DUT made a %s", $time,
                     e_kind ? "store" : "register write", kind ? "store" : "register write");
            error_count++;
            test_errors[t]++;
        end else if (kind) begin
            check_value("st_addr_o", e_where, where);
            check_value("st_data_o", e_data, data);
        end else begin
            check_value("wb_reg_o", e_where, where);
            check_value("wb_data_o", e_data, data);
        end
        if (exp_test.size() == 0 || exp_test[0] != t) begin
            report_test(t);
        end
    endtask

    // the older instruction retires in writeback before a store in memory
    always @(negedge clk) begin
        if (wb_en) begin
            take_event(1'b0, {27'd0, wb_reg}, wb_data);
        end
        if (st_en) begin
            take_event(1'b1, st_addr, st_data);
        end
    end

    initial begin
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic        halted;
        for (int i = 0; i < NUM_TESTS; i++) begin
            test_events[i] = 0;
            test_errors[i] = 0;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        for (int i = 0; i < int'(IMEM_WORDS); i++) begin
            prog[i] = 32'd0;
        end
        for (int i = 0; i < int'(DMEM_WORDS); i++) begin
            model_mem[i] = 32'd0;
        end
        $readmemh("test/program.hex", prog);

        // halt is a jump to its own address
        pc     = RESET_PC;
        halted = 1'b0;
        while (!halted && model_steps < MAX_STEPS) begin
            next_pc = model_step(pc);
            model_steps++;
            halted = (next_pc == pc);
            pc     = next_pc;
        end
        if (!halted) begin
            $display("the reference model never reached the halt instruction");
            error_count++;
        end
        model_done = 1'b1;

        while (reset) @(negedge clk);
        while (exp_kind.size() != 0) @(negedge clk);
        // time for a stray event after the halt to show
        repeat (20) @(negedge clk);
        $display("tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        wait (model_done);
        repeat (3 * model_steps + 100) @(posedge clk);
        $display("timeout after %0d cycles, %0d expected events never appeared",
                 3 * model_steps + 100, exp_kind.size());
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/program.hex
// one 32-bit instruction word per line in hex, starting at address 0
24010007  // alu: addiu $1, $0, 7
2402fffb  // addiu $2, $0, -5
00221821  // addu $3, $1, $2
00412023  // subu $4, $2, $1
00222824  // and $5, $1, $2
00223025  // or $6, $1, $2
0041382a  // slt $7, $2, $1
0022402a  // slt $8, $1, $2
24090003  // forwarding: addiu $9, $0, 3
01295021  // addu $10, $9, $9
01495821  // addu $11, $10, $9
016a6023  // subu $12, $11, $10
ac0b0010  // memory: sw $11, 16($0)
8c0d0010  // lw $13, 16($0)
01a17021  // addu $14, $13, $1 after the load
ac0e0014  // sw $14, 20($0)
10220005  // branches: beq $1, $2, 5 not taken
116d0002  // beq $11, $13, 2 taken
240f0055  // addiu $15, $0, 0x55 skipped
ac0f0018  // sw $15, 24($0) skipped
24100011  // addiu $16, $0, 0x11 branch target
24000123  // jump: addiu $0, $0, 0x123
00019021  // addu $18, $0, $1
08000019  // j 25
24110001  // addiu $17, $0, 1 skipped
02509825  // or $19, $18, $16 jump target
0800001a  // j 26 halt

// File: flist.f
src/mips_pkg.sv
src/decode.sv
src/regfile.sv
src/alu.sv
src/hazard_unit.sv
src/mips_core.sv
src/instr_rom.sv
src/data_ram.sv
src/mips_top.sv
test/tb_clock_gen.sv
test/tb_mips_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MIPS testbench with Verilator
set -e
cd "$(dirname "$0")"

# the instruction ROM loads program.hex from the working directory
cp test/program.hex program.hex

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_mips_top -Mdir obj_dir -f flist.f

./obj_dir/Vtb_mips_top | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi
